/* video_frame_top.f */
rtl/video_pkg.sv
rtl/raster_timing.sv
rtl/camera_capture.sv
rtl/frame_store.sv
rtl/display_reader.sv
rtl/video_frame_top.sv
test/video_frame_tb.sv

/* Bender.yml */
package:
  name: video_frame

sources:
  - files:
      - rtl/video_pkg.sv
      - rtl/raster_timing.sv
      - rtl/camera_capture.sv
      - rtl/frame_store.sv
      - rtl/display_reader.sv
      - rtl/video_frame_top.sv
  - target: test
    files:
      - test/video_frame_tb.sv

/* test/video_frame_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module video_frame_tb
   import video_pkg::*;
;

   // raster geometry, same values the top level uses by default
   localparam int H_ACTIVE     = 64;
   localparam int H_TOTAL      = 80;
   localparam int V_ACTIVE     = 48;
   localparam int V_TOTAL      = 56;
   localparam int FRAME_PIX    = H_ACTIVE * V_ACTIVE;
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 10;
   // eight frame times plus reset is enough for the whole sequence
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + 8 * FRAME_CYCLES;

   logic   clk;
   logic   reset;
   logic   cam_valid;
   logic   cam_sof;
   pixel_t cam_luma;
   logic   clear_mode;
   logic   bars_mode;
   pixel_t pixel;
   logic   hsync_n;
   logic   vsync_n;
   logic   blank_n;

   // reference picture, one thresholded value per visible pixel
   pixel_t ref_frame [FRAME_PIX];
   int     seed;

   // raster tracking, all updated on the rising edge
   int   cyc;
   logic hs_prev;
   logic vs_prev;
   logic bn_prev;
   logic hs_seen;
   logic vs_seen;
   int   hs_last;
   int   vs_last;
   int   run_len;
   // index of the visible pixel on the output, counted from vsync
   int   pos;
   int   frame_count;
   logic hs_fall;
   logic vs_fall;
   logic line_end;

   // which group of checks is armed
   logic raster_on;
   logic bars_on;
   logic cap_on;
   logic clear_on;

   int raster_hits = 0;
   int raster_errs = 0;
   int blank_hits  = 0;
   int blank_errs  = 0;
   int bars_hits   = 0;
   int bars_errs   = 0;
   int cap_hits    = 0;
   int cap_errs    = 0;
   int clear_hits  = 0;
   int clear_errs  = 0;
   int failed_tests = 0;
   int total_errs   = 0;

   video_frame_top dut0 (
      .clk(clk), .reset(reset), .cam_valid(cam_valid), .cam_sof(cam_sof),
      .cam_luma(cam_luma), .clear_mode(clear_mode), .bars_mode(bars_mode),
      .pixel(pixel), .hsync_n(hsync_n), .vsync_n(vsync_n), .blank_n(blank_n)
   );

   ////////////////////
   // clock and watchdog
   ////////////////////

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog: the test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

   ////////////////////
   // output tracking
   ////////////////////

   assign hs_fall  = hs_prev && !hsync_n;
   assign vs_fall  = vs_prev && !vsync_n;
   assign line_end = bn_prev && !blank_n;

   // bar level for a visible column, eight columns per bar
   function automatic pixel_t expected_bar(input int x);
      return pixel_t'((x / 8) * 32);
   endfunction

   always @(posedge clk) begin
      if (reset) begin
         cyc         <= 0;
         hs_prev     <= 1'b1;
         vs_prev     <= 1'b1;
         bn_prev     <= 1'b0;
         hs_seen     <= 1'b0;
         vs_seen     <= 1'b0;
         hs_last     <= 0;
         vs_last     <= 0;
         run_len     <= 0;
         pos         <= 0;
         frame_count <= 0;
      end else begin
         cyc     <= cyc + 1;
         hs_prev <= hsync_n;
         vs_prev <= vsync_n;
         bn_prev <= blank_n;
         run_len <= blank_n ? run_len + 1 : 0;
         if (hs_fall) begin
            hs_last <= cyc;
            hs_seen <= 1'b1;
         end
         // new frame restarts the pixel index
         if (vs_fall) begin
            vs_last     <= cyc;
            vs_seen     <= 1'b1;
            frame_count <= frame_count + 1;
            pos         <= 0;
         end else if (blank_n) begin
            pos <= pos + 1;
         end
         // count how often each check is reached
         if (raster_on && ((hs_fall && hs_seen) || (vs_fall && vs_seen) || line_end)) begin
            raster_hits <= raster_hits + 1;
         end
         if (!blank_n) begin
            blank_hits <= blank_hits + 1;
         end
         if (bars_on && blank_n) begin
            bars_hits <= bars_hits + 1;
         end
         if (cap_on && blank_n) begin
            cap_hits <= cap_hits + 1;
         end
         if (clear_on && blank_n) begin
            clear_hits <= clear_hits + 1;
         end
      end
   end

   ////////////////////
   // checks
   ////////////////////

   hsync_period_chk: assert property (@(posedge clk) disable iff (reset)
      raster_on && hs_fall && hs_seen |-> (cyc - hs_last) == H_TOTAL)
      else begin
         raster_errs++;
         $display("ERROR %0t: hsync period %0d cycles, expected %0d", $time,
                  $sampled(cyc) - $sampled(hs_last), H_TOTAL);
      end

   vsync_period_chk: assert property (@(posedge clk) disable iff (reset)
      raster_on && vs_fall && vs_seen |-> (cyc - vs_last) == FRAME_CYCLES)
      else begin
         raster_errs++;
         $display("ERROR %0t: vsync period %0d cycles, expected %0d", $time,
                  $sampled(cyc) - $sampled(vs_last), FRAME_CYCLES);
      end

   // visible run of each line
   line_width_chk: assert property (@(posedge clk) disable iff (reset)
      raster_on && line_end |-> run_len == H_ACTIVE)
      else begin
         raster_errs++;
         $display("ERROR %0t: visible line of %0d pixels, expected %0d", $time,
                  $sampled(run_len), H_ACTIVE);
      end

   blank_black_chk: assert property (@(posedge clk) disable iff (reset)
      !blank_n |-> pixel == 8'd0)
      else begin
         blank_errs++;
         $display("ERROR %0t: pixel %0d during blanking, expected 0", $time, $sampled(pixel));
      end

   bars_chk: assert property (@(posedge clk) disable iff (reset)
      bars_on && blank_n |-> pixel == expected_bar(pos % H_ACTIVE))
      else begin
         bars_errs++;
         $display("ERROR %0t: bar pixel at col %0d is %0d, expected %0d", $time,
                  $sampled(pos) % H_ACTIVE, $sampled(pixel),
                  expected_bar($sampled(pos) % H_ACTIVE));
      end

   capture_chk: assert property (@(posedge clk) disable iff (reset)
      cap_on && blank_n |-> pixel == ref_frame[pos])
      else begin
         cap_errs++;
         $display("ERROR %0t: stored pixel at row %0d col %0d is %0d, expected %0d", $time,
                  $sampled(pos) / H_ACTIVE, $sampled(pos) % H_ACTIVE, $sampled(pixel),
                  ref_frame[$sampled(pos)]);
      end

   clear_chk: assert property (@(posedge clk) disable iff (reset)
      clear_on && blank_n |-> pixel == 8'd0)
      else begin
         clear_errs++;
         $display("ERROR %0t: pixel at row %0d col %0d is %0d after clear, expected 0", $time,
                  $sampled(pos) / H_ACTIVE, $sampled(pos) % H_ACTIVE, $sampled(pixel));
      end

   ////////////////////
   // stimulus helpers
   ////////////////////

   // returns on the edge just after the n-th following vsync fall
   task automatic wait_frames(input int n);
      int target;
      target = frame_count + n;
      while (frame_count != target) begin
         @(posedge clk);
      end
   endtask

   // one camera frame, with random idle clocks between samples
   task automatic send_camera_frame();
      int     i;
      int     r;
      pixel_t s;
      i = 0;
      while (i < FRAME_PIX) begin
         @(posedge clk);
         r = $random(seed);
         if (r[2:0] == 3'd0) begin
            cam_valid <= 1'b0;
            cam_sof   <= 1'b0;
         end else begin
            s = r[15:8];
            cam_valid <= 1'b1;
            cam_sof   <= (i == 0);
            cam_luma  <= s;
            // threshold rule, white strictly above 127
            ref_frame[i] = (s > 8'd127) ? 8'd255 : 8'd0;
            i++;
         end
      end
      @(posedge clk);
      cam_valid <= 1'b0;
      cam_sof   <= 1'b0;
   endtask

   task automatic report_test(input string name, input int hits, input int errs,
                              input int need);
      if (hits < need) begin
         $display("test %s: check reached only %0d times, needed %0d", name, hits, need);
         failed_tests++;
      end else if (errs != 0) begin
         $display("test %s: %0d checks, %0d errors", name, hits, errs);
         failed_tests++;
      end else begin
         $display("test %s: %0d checks, passed", name, hits);
      end
      total_errs += errs;
   endtask

   ////////////////////
   // test sequence
   ////////////////////

   initial begin
      seed       = 6;
      reset      <= 1'b1;
      cam_valid  <= 1'b0;
      cam_sof    <= 1'b0;
      cam_luma   <= '0;
      clear_mode <= 1'b0;
      bars_mode  <= 1'b0;
      raster_on  <= 1'b1;
      bars_on    <= 1'b0;
      cap_on     <= 1'b0;
      clear_on   <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      // raster timing until two vsync falls have been seen
      wait_frames(2);
      raster_on <= 1'b0;
      report_test("raster timing", raster_hits, raster_errs, 2 * V_TOTAL);

      // bars shown while the camera frame is written behind them
      bars_mode <= 1'b1;
      bars_on   <= 1'b1;
      send_camera_frame();
      wait_frames(1);
      bars_mode <= 1'b0;
      bars_on   <= 1'b0;
      report_test("test bars", bars_hits, bars_errs, FRAME_PIX);

      // camera is idle, this whole frame shows the stored picture
      cap_on <= 1'b1;
      wait_frames(1);
      cap_on <= 1'b0;
      report_test("capture", cap_hits, cap_errs, FRAME_PIX);

      // two frames of clear, then one frame that must be black
      clear_mode <= 1'b1;
      wait_frames(2);
      clear_mode <= 1'b0;
      clear_on   <= 1'b1;
      wait_frames(1);
      clear_on <= 1'b0;
      report_test("clear", clear_hits, clear_errs, FRAME_PIX);

      // blanking was watched through every mode above
      report_test("blanking", blank_hits, blank_errs, FRAME_CYCLES - FRAME_PIX);

      $display("tests run: 5, tests failed: %0d, errors: %0d", failed_tests, total_errs);
      if (failed_tests == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/video_frame_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_frame_top
   import video_pkg::*;
#(
   parameter int H_ACTIVE    = 64,
   parameter int H_TOTAL     = 80,
   parameter int HSYNC_START = 68,
   parameter int HSYNC_LEN   = 6,
   parameter int V_ACTIVE    = 48,
   parameter int V_TOTAL     = 56,
   parameter int VSYNC_START = 50,
   parameter int VSYNC_LEN   = 2,
   parameter int ADDR_W      = 10,
   localparam type hcount_t  = logic [7:0],
   localparam type vcount_t  = logic [7:0],
   localparam type addr_t    = logic [ADDR_W-1:0]
) (
   input  wire    clk,
   input  wire    reset,
   input  wire    cam_valid,
   input  wire    cam_sof,
   input  pixel_t cam_luma,
   input  wire    clear_mode,
   input  wire    bars_mode,
   output pixel_t pixel,
   output logic   hsync_n,
   output logic   vsync_n,
   output logic   blank_n
);

   // raster to store and reader
   hcount_t   hcount;
   vcount_t   vcount;
   logic      raw_hsync_n;
   logic      raw_vsync_n;
   logic      blank;
   // camera write handshake
   logic      wr_pending;
   logic      wr_taken;
   addr_t     wr_addr;
   mem_word_t wr_data;
   // display read path
   addr_t     rd_addr;
   mem_word_t rd_data;

   raster_timing #(
      .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
      .HSYNC_START(HSYNC_START), .HSYNC_LEN(HSYNC_LEN),
      .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
      .VSYNC_START(VSYNC_START), .VSYNC_LEN(VSYNC_LEN)
   ) timing0 (
      .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount),
      .hsync_n(raw_hsync_n), .vsync_n(raw_vsync_n), .blank(blank)
   );

   // capture decodes the camera stream into words
   camera_capture #(.ADDR_W(ADDR_W)) capture0 (
      .clk(clk), .reset(reset), .cam_valid(cam_valid), .cam_sof(cam_sof),
      .cam_luma(cam_luma), .wr_taken(wr_taken), .wr_pending(wr_pending),
      .wr_addr(wr_addr), .wr_data(wr_data)
   );

   frame_store #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .ADDR_W(ADDR_W)) store0 (
      .clk(clk), .reset(reset), .hcount(hcount), .blank(blank),
      .clear_mode(clear_mode), .wr_pending(wr_pending), .wr_addr(wr_addr),
      .wr_data(wr_data), .rd_addr(rd_addr), .wr_taken(wr_taken), .rd_data(rd_data)
   );

   display_reader #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .ADDR_W(ADDR_W)) reader0 (
      .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount),
      .hsync_n(raw_hsync_n), .vsync_n(raw_vsync_n), .blank(blank),
      .bars_mode(bars_mode), .rd_data(rd_data), .rd_addr(rd_addr), .pixel(pixel),
      .hsync_n_out(hsync_n), .vsync_n_out(vsync_n), .blank_n(blank_n)
   );

endmodule

`default_nettype wire

/* rtl/display_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module display_reader
   import video_pkg::*;
#(
   parameter int H_ACTIVE    = 64,
   parameter int V_ACTIVE    = 48,
   parameter int ADDR_W      = 10,
   localparam type hcount_t  = logic [7:0],
   localparam type vcount_t  = logic [7:0],
   localparam type addr_t    = logic [ADDR_W-1:0]
) (
   input  wire       clk,
   input  wire       reset,
   input  hcount_t   hcount,
   input  vcount_t   vcount,
   input  wire       hsync_n,
   input  wire       vsync_n,
   input  wire       blank,
   input  wire       bars_mode,
   input  mem_word_t rd_data,
   output addr_t     rd_addr,
   output pixel_t    pixel,
   output logic      hsync_n_out,
   output logic      vsync_n_out,
   output logic      blank_n
);

   localparam int WORDS_PER_LINE = H_ACTIVE / WORD_PIXELS;
   localparam int PIX_W          = $bits(pixel_t);

   slot_t     phase;
   vcount_t   row_cur;
   vcount_t   row_next;
   vcount_t   fetch_row;
   hcount_t   fetch_col;
   // word being shown for the current group of four
   mem_word_t unpack_word;
   pixel_t    stored_pix;
   pixel_t    bar_pix;

   ////////////////////
   // prefetch address
   ////////////////////

   always_comb begin
      phase    = slot_t'(hcount[1:0]);
      // rows outside the picture fall back to the top row
      row_cur  = (vcount < vcount_t'(V_ACTIVE)) ? vcount : '0;
      row_next = (vcount < vcount_t'(V_ACTIVE - 1)) ? vcount + 1'b1 : '0;
      // next group on this line, or the start of the next visible line
      if ((int'(hcount) + WORD_PIXELS) < H_ACTIVE) begin
         fetch_row = row_cur;
         fetch_col = hcount_t'((int'(hcount) + WORD_PIXELS) / WORD_PIXELS);
      end else begin
         fetch_row = row_next;
         fetch_col = '0;
      end
      rd_addr = addr_t'(int'(fetch_row) * WORDS_PER_LINE + int'(fetch_col));
   end

   ////////////////////
   // unpack and output
   ////////////////////

   // returned word lands on slot_write, take it at the end of the group
   always_ff @(posedge clk) begin
      if (phase == slot_idle3) begin
         unpack_word <= rd_data;
      end
   end

   always_comb begin
      // lane picked by the low count bits, low byte first
      stored_pix = unpack_word[int'(hcount[1:0]) * PIX_W +: PIX_W];
      // eight-pixel wide vertical bars
      bar_pix    = pixel_t'((int'(hcount) / 8) * 32);
   end

   // one clock behind the raster, syncs delayed to match
   always_ff @(posedge clk) begin
      if (reset) begin
         pixel       <= '0;
         hsync_n_out <= 1'b1;
         vsync_n_out <= 1'b1;
         blank_n     <= 1'b0;
      end else begin
         pixel       <= blank ? '0 : (bars_mode ? bar_pix : stored_pix);
         hsync_n_out <= hsync_n;
         vsync_n_out <= vsync_n;
         blank_n     <= !blank;
      end
   end

endmodule

`default_nettype wire

/* rtl/frame_store.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_store
   import video_pkg::*;
#(
   parameter int H_ACTIVE    = 64,
   parameter int V_ACTIVE    = 48,
   parameter int ADDR_W      = 10,
   localparam type hcount_t  = logic [7:0],
   localparam type addr_t    = logic [ADDR_W-1:0]
) (
   input  wire       clk,
   input  wire       reset,
   input  hcount_t   hcount,
   input  wire       blank,
   input  wire       clear_mode,
   input  wire       wr_pending,
   input  addr_t     wr_addr,
   input  mem_word_t wr_data,
   input  addr_t     rd_addr,
   output logic      wr_taken,
   output mem_word_t rd_data
);

   // one word per group of four visible pixels
   localparam int WORDS = H_ACTIVE * V_ACTIVE / WORD_PIXELS;

   mem_word_t mem [WORDS];

   slot_t     phase;
   addr_t     clr_addr;
   logic      clr_we;
   logic      mem_we;
   addr_t     mem_addr;
   mem_word_t mem_wdata;
   // first read stage, straight out of the array
   mem_word_t rd_q;

   ////////////////////
   // slot arbitration
   ////////////////////

   always_comb begin
      phase     = slot_t'(hcount[1:0]);
      // clear sweep uses every blanked slot except the read
      clr_we    = clear_mode && blank && (phase != slot_read);
      // camera only gets its own slot, and never while clearing
      wr_taken  = (phase == slot_write) && !clear_mode && wr_pending;
      mem_we    = clr_we || wr_taken;
      mem_wdata = clr_we ? '0 : wr_data;
      // single port, write address wins whenever a write is due
      if (clr_we) begin
         mem_addr = clr_addr;
      end else if (wr_taken) begin
         mem_addr = wr_addr;
      end else begin
         mem_addr = rd_addr;
      end
   end

   // clear sweep pointer, wraps at the word count
   always_ff @(posedge clk) begin
      if (reset) begin
         clr_addr <= '0;
      end else if (clr_we) begin
         clr_addr <= (clr_addr == addr_t'(WORDS - 1)) ? '0 : clr_addr + 1'b1;
      end
   end

   ////////////////////
   // memory and read pipe
   ////////////////////

   // read sampled on slot_read, out of the second stage on slot_write
   always_ff @(posedge clk) begin
      if (mem_we) begin
         mem[mem_addr] <= mem_wdata;
      end
      if (phase == slot_read) begin
         rd_q <= mem[mem_addr];
      end
      rd_data <= rd_q;
   end

   // the display read slot must address a word inside the picture
   assert property (@(posedge clk) disable iff (reset)
      (phase == slot_read) |-> (rd_addr < addr_t'(WORDS)))
      else $error("display read outside the frame store");

endmodule

`default_nettype wire

/* rtl/camera_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module camera_capture
   import video_pkg::*;
#(
   parameter int ADDR_W    = 10,
   localparam type addr_t  = logic [ADDR_W-1:0]
) (
   input  wire       clk,
   input  wire       reset,
   input  wire       cam_valid,
   input  wire       cam_sof,
   input  pixel_t    cam_luma,
   input  wire       wr_taken,
   output logic      wr_pending,
   output addr_t     wr_addr,
   output mem_word_t wr_data
);

   localparam int LANE_W = $clog2(WORD_PIXELS);
   localparam int PIX_W  = $bits(pixel_t);
   localparam int WORD_W = $bits(mem_word_t);

   // lane of the next sample inside the current group
   logic [LANE_W-1:0] lane;
   logic [LANE_W-1:0] lane_now;
   // address the next finished word will take
   addr_t             word_idx;
   addr_t             base_idx;
   mem_word_t         pack;
   mem_word_t         next_pack;
   pixel_t            sample_bw;
   logic              word_done;

   ////////////////////
   // threshold and pack
   ////////////////////

   always_comb begin
      sample_bw = (cam_luma > THRESHOLD) ? '1 : '0;
      // start of frame forces a fresh group at word 0
      lane_now  = cam_sof ? '0 : lane;
      base_idx  = cam_sof ? '0 : word_idx;
      // shift right so the first sample ends up in the low byte
      next_pack = {sample_bw, pack[WORD_W-1:PIX_W]};
      word_done = cam_valid && (lane_now == LANE_W'(WORD_PIXELS - 1));
   end

   // lane, address and handshake state
   always_ff @(posedge clk) begin
      if (reset) begin
         lane       <= '0;
         word_idx   <= '0;
         wr_pending <= 1'b0;
      end else begin
         if (cam_valid) begin
            lane     <= lane_now + 1'b1;
            word_idx <= word_done ? base_idx + 1'b1 : base_idx;
         end
         // a fresh word wins over the slot draining the old one
         if (word_done) begin
            wr_pending <= 1'b1;
         end else if (wr_taken) begin
            wr_pending <= 1'b0;
         end
      end
   end

   // pack register and one-word hold
   always_ff @(posedge clk) begin
      if (cam_valid) begin
         pack <= next_pack;
      end
      if (word_done) begin
         wr_data <= next_pack;
         wr_addr <= base_idx;
      end
   end

   // write slot comes every 4 clocks, so the hold must be empty or draining
   assert property (@(posedge clk) disable iff (reset)
      word_done |-> (!wr_pending || wr_taken))
      else $error("camera word overran the hold register");

endmodule

`default_nettype wire

/* rtl/raster_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_timing #(
   parameter int H_ACTIVE    = 64,
   parameter int H_TOTAL     = 80,
   parameter int HSYNC_START = 68,
   parameter int HSYNC_LEN   = 6,
   parameter int V_ACTIVE    = 48,
   parameter int V_TOTAL     = 56,
   parameter int VSYNC_START = 50,
   parameter int VSYNC_LEN   = 2,
   localparam type hcount_t  = logic [7:0],
   localparam type vcount_t  = logic [7:0]
) (
   input  wire     clk,
   input  wire     reset,
   output hcount_t hcount,
   output vcount_t vcount,
   output logic    hsync_n,
   output logic    vsync_n,
   output logic    blank
);

   // last count of each axis
   localparam hcount_t H_LAST = hcount_t'(H_TOTAL - 1);
   localparam vcount_t V_LAST = vcount_t'(V_TOTAL - 1);

   ////////////////////
   // pixel and line counters
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         hcount <= '0;
         vcount <= '0;
      end else if (hcount == H_LAST) begin
         hcount <= '0;
         // line steps only when the pixel count wraps
         vcount <= (vcount == V_LAST) ? '0 : vcount + 1'b1;
      end else begin
         hcount <= hcount + 1'b1;
      end
   end

   ////////////////////
   // sync and blank windows
   ////////////////////

   always_comb begin
      // outside the visible rectangle on either axis
      blank   = (hcount >= hcount_t'(H_ACTIVE)) || (vcount >= vcount_t'(V_ACTIVE));
      // active low pulses, whole lines for vertical
      hsync_n = !((hcount >= hcount_t'(HSYNC_START)) &&
                  (hcount <  hcount_t'(HSYNC_START + HSYNC_LEN)));
      vsync_n = !((vcount >= vcount_t'(VSYNC_START)) &&
                  (vcount <  vcount_t'(VSYNC_START + VSYNC_LEN)));
   end

   // sync pulses have to sit inside the blanking interval on both axes
   assert property (@(posedge clk) disable iff (reset) (!hsync_n || !vsync_n) |-> blank)
      else $error("sync pulse overlaps the visible area");

endmodule

`default_nettype wire

/* rtl/video_pkg.sv */
`default_nettype none

package video_pkg;

   ////////////////////
   // pixel and word types
   ////////////////////

   // one 8-bit luma sample, black is 0 and white is 255
   typedef logic [7:0] pixel_t;

   // four pixels per memory word
   // leftmost pixel of the group sits in the low byte
   typedef logic [31:0] mem_word_t;

   // number of pixels packed into one word
   // used to step word addresses and lane counters
   localparam int WORD_PIXELS = 4;

   ////////////////////
   // memory slot schedule
   ////////////////////

   // phase of the low two horizontal count bits
   // the frame store has one port, so it is shared by time
   // phase 0 belongs to the display read
   // phase 2 belongs to the camera write
   // phases 1 and 3 are free for the clear sweep only
   typedef enum logic [1:0] {
      slot_read  = 2'd0,
      slot_idle1 = 2'd1,
      slot_write = 2'd2,
      slot_idle3 = 2'd3
   } slot_t;

   ////////////////////
   // capture tuning
   ////////////////////

   // samples strictly above this level become white
   // everything else becomes black
   localparam pixel_t THRESHOLD = 8'd127;

endpackage

`default_nettype wire
